//--- bench/tb_system.sv
module tb_system;
	timeunit 1ns;
	timeprecision 100ps;
	import system_pkg::*;

	localparam int CLK_PER_MS = 8;
	localparam int JOY_BYTES  = 24;

	localparam logic [2:0] OP_RD    = 3'd0;
	localparam logic [2:0] OP_WR    = 3'd1;
	localparam logic [2:0] OP_DN0   = 3'd2;
	localparam logic [2:0] OP_DN1   = 3'd3;
	localparam logic [2:0] OP_IDLE  = 3'd4;
	localparam logic [2:0] OP_PAUSE = 3'd5;
	localparam logic [2:0] OP_MENU  = 3'd6;
	localparam logic [2:0] OP_WAIT  = 3'd7;

	// A read passes when the returned byte lies in lo..hi
	typedef struct packed {
		logic [2:0]  op;
		logic [16:0] addr;
		logic [7:0]  data;
		logic [7:0]  lo;
		logic [7:0]  hi;
	} entry_t;

	logic                   clk_24;
	logic                   arst_n;
	addr_t                  bus_addr;
	byte_t                  bus_wdata;
	logic                   bus_rd;
	logic                   bus_wr;
	byte_t                  bus_rdata;
	logic                   bus_rvalid;
	logic                   bus_wait;
	dn_addr_t               dn_addr;
	byte_t                  dn_data;
	logic                   dn_wr;
	byte_t                  dn_index;
	logic                   menu;
	logic                   pause;
	logic [JOY_BYTES*8-1:0] joystick;
	logic [32:0]            timestamp;
	logic                   debug;

	entry_t      table_q[$];
	logic [15:0] pend_addr[$];
	logic [7:0]  pend_lo[$];
	logic [7:0]  pend_hi[$];
	int          pend_edge[$];
	byte_t       dl_data[64];
	logic [31:0] lfsr;
	logic [31:0] rnd;
	int          cycle_cnt = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          failed = 0;
	int          i;
	logic [15:0] m_addr;
	logic [7:0]  m_lo;
	logic [7:0]  m_hi;
	logic [7:0]  m_exp;
	int          m_edge;

	system_top #(
		.CLK_PER_MS (CLK_PER_MS),
		.JOY_BYTES  (JOY_BYTES)
	) dut_i (
		.clk_24     (clk_24),
		.arst_n     (arst_n),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.bus_rd     (bus_rd),
		.bus_wr     (bus_wr),
		.bus_rdata  (bus_rdata),
		.bus_rvalid (bus_rvalid),
		.bus_wait   (bus_wait),
		.dn_addr    (dn_addr),
		.dn_data    (dn_data),
		.dn_wr      (dn_wr),
		.dn_index   (dn_index),
		.menu       (menu),
		.pause      (pause),
		.joystick   (joystick),
		.timestamp  (timestamp),
		.debug      (debug)
	);

	initial
		clk_24 = 1'b0;
	always #2 clk_24 = ~clk_24;

	always @(posedge clk_24)
		cycle_cnt <= cycle_cnt + 1;

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++)
		begin
			v = {v[30:0], lfsr[31]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic byte_t joy_byte_at(input int off);
		if (off < JOY_BYTES)
			return joystick[off*8 +: 8];
		return 8'h00;
	endfunction

	// 33-bit timestamp spans five bytes, the top one holds a single bit
	function automatic byte_t ts_byte_at(input int off);
		logic [39:0] w;
		w = {7'b0000000, timestamp};
		if (off < 5)
			return w[off*8 +: 8];
		return 8'h00;
	endfunction

	task add_entry(input logic [2:0] op, input int addr, input int data, input int lo,
		input int hi);
		entry_t e;
		e.op   = op;
		e.addr = addr[16:0];
		e.data = data[7:0];
		e.lo   = lo[7:0];
		e.hi   = hi[7:0];
		table_q.push_back(e);
	endtask

	// One entry per clock, driven just after the rising edge
	task apply_entry(input entry_t e);
		@(posedge clk_24);
		#1;
		bus_rd = 1'b0;
		bus_wr = 1'b0;
		dn_wr  = 1'b0;
		pause  = 1'b0;
		case (e.op)
			OP_RD:
			begin
				bus_addr = e.addr[15:0];
				bus_rd   = 1'b1;
				pend_addr.push_back(e.addr[15:0]);
				pend_lo.push_back(e.lo);
				pend_hi.push_back(e.hi);
				pend_edge.push_back(cycle_cnt + 1);
			end
			OP_WR:
			begin
				bus_addr  = e.addr[15:0];
				bus_wdata = e.data;
				bus_wr    = 1'b1;
			end
			OP_DN0, OP_DN1:
			begin
				dn_addr  = e.addr;
				dn_data  = e.data;
				dn_index = (e.op == OP_DN1) ? 8'd1 : 8'd0;
				dn_wr    = 1'b1;
			end
			OP_IDLE:
				for (int n = 1; n < e.addr; n++)
					@(posedge clk_24);
			OP_PAUSE:
				pause = 1'b1;
			OP_MENU:
				menu = e.data[0];
			OP_WAIT:
			begin
				#1;
				check_value("bus_wait", bus_wait, e.data);
			end
			default:
				;
		endcase
	endtask

	task run_table(input string name);
		int err_start;
		int waited;
		err_start = errors;
		foreach (table_q[k])
			apply_entry(table_q[k]);
		@(posedge clk_24);
		#1;
		bus_rd = 1'b0;
		bus_wr = 1'b0;
		dn_wr  = 1'b0;
		pause  = 1'b0;
		waited = 0;
		while (pend_edge.size() != 0 && waited < 10)
		begin
			@(posedge clk_24);
			waited++;
		end
		if (pend_edge.size() != 0)
		begin
			$display("ERROR at %0t: %0d read(s) never returned bus_rvalid within 10 cycles",
				$time, pend_edge.size());
			errors++;
			pend_addr.delete();
			pend_lo.delete();
			pend_hi.delete();
			pend_edge.delete();
		end
		table_q.delete();
		tests++;
		if (errors != err_start)
			failed++;
		$display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "errors");
	endtask

	// Read responses are matched in issue order at the falling edge
	always @(negedge clk_24)
	begin
		if (arst_n && bus_rvalid)
		begin
			if (pend_edge.size() == 0)
			begin
				$display("ERROR at %0t: bus_rvalid high with no read outstanding", $time);
				errors++;
			end
			else
			begin
				m_addr = pend_addr.pop_front();
				m_lo   = pend_lo.pop_front();
				m_hi   = pend_hi.pop_front();
				m_edge = pend_edge.pop_front();
				if ($isunknown(bus_rdata) || bus_rdata < m_lo)
					m_exp = m_lo;
				else if (bus_rdata > m_hi)
					m_exp = m_hi;
				else
					m_exp = bus_rdata;
				check_value($sformatf("bus_rdata[%h]", m_addr), bus_rdata, m_exp);
				// The response is taken at the next rising edge
				check_value("bus_rvalid latency", cycle_cnt + 1 - m_edge, 2);
			end
		end
	end

	initial
	begin
		arst_n    = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		bus_rd    = 1'b0;
		bus_wr    = 1'b0;
		dn_addr   = '0;
		dn_data   = '0;
		dn_wr     = 1'b0;
		dn_index  = '0;
		menu      = 1'b0;
		pause     = 1'b0;
		debug     = 1'b1;
		lfsr      = 32'd79461;
		for (i = 0; i < JOY_BYTES; i++)
		begin
			rand_bits(8, rnd);
			joystick[i*8 +: 8] = rnd[7:0];
		end
		rand_bits(32, rnd);
		timestamp[31:0] = rnd;
		rand_bits(1, rnd);
		timestamp[32] = rnd[0];
		for (i = 0; i < 64; i++)
		begin
			rand_bits(8, rnd);
			dl_data[i] = rnd[7:0];
		end
		repeat (2) @(posedge clk_24);
		#1;
		arst_n = 1'b1;

		for (i = 0; i < 64; i++)
			add_entry(OP_DN0, 'h100 + i, dl_data[i], 0, 0);
		for (i = 0; i < 64; i++)
			add_entry(OP_RD, 'h100 + i, 0, dl_data[i], dl_data[i]);
		run_table("program ROM download and back-to-back readback");

		add_entry(OP_WR, 'hC000, 'hA5, 0, 0);
		add_entry(OP_RD, 'hC000, 0, 'hA5, 'hA5);
		add_entry(OP_WR, 'hE123, 'h5A, 0, 0);
		add_entry(OP_RD, 'hE123, 0, 'h5A, 'h5A);
		add_entry(OP_WR, 'hFFFF, 'h3C, 0, 0);
		add_entry(OP_RD, 'hFFFF, 0, 'h3C, 'h3C);
		add_entry(OP_RD, 'hC000, 0, 'hA5, 'hA5);
		add_entry(OP_DN1, 'h105, ~dl_data[5], 0, 0);
		add_entry(OP_RD, 'h105, 0, dl_data[5], dl_data[5]);
		run_table("work RAM and download index filter");

		for (i = 0; i < JOY_BYTES + 2; i++)
			add_entry(OP_RD, 'h8100 + i, 0, joy_byte_at(i), joy_byte_at(i));
		add_entry(OP_RD, 'h81FF, 0, 0, 0);
		for (i = 0; i < 7; i++)
			add_entry(OP_RD, 'h8800 + i, 0, ts_byte_at(i), ts_byte_at(i));
		add_entry(OP_RD, 'h8500, 0, 0, 0);
		run_table("joystick, timestamp and unmapped reads");

		add_entry(OP_WR, 'h8900, 0, 0, 0);
		add_entry(OP_IDLE, 5 * CLK_PER_MS, 0, 0, 0);
		add_entry(OP_RD, 'h8900, 0, 4, 6);
		add_entry(OP_RD, 'h8901, 0, 0, 0);
		run_table("millisecond timer clear and count");

		add_entry(OP_WAIT, 0, 0, 0, 0);
		add_entry(OP_WR, 'h8A30, 0, 0, 0);
		add_entry(OP_WAIT, 0, 1, 0, 0);
		add_entry(OP_IDLE, 3, 0, 0, 0);
		add_entry(OP_WAIT, 0, 1, 0, 0);
		add_entry(OP_PAUSE, 0, 0, 0, 0);
		add_entry(OP_WAIT, 0, 0, 0, 0);
		add_entry(OP_MENU, 0, 1, 0, 0);
		add_entry(OP_RD, 'h8000, 0, 'h03, 'h03);
		add_entry(OP_IDLE, 1, 0, 0, 0);
		add_entry(OP_MENU, 0, 0, 0, 0);
		add_entry(OP_RD, 'h8A40, 0, 'hFF, 'hFF);
		add_entry(OP_RD, 'h8000, 0, 'h01, 'h01);
		add_entry(OP_WR, 'h8A40, 0, 0, 0);
		add_entry(OP_RD, 'h8A40, 0, 0, 0);
		run_table("pause wait and menu trigger");

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- common/system_pkg.sv
package system_pkg;

	// Bus and download widths
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [16:0] dn_addr_t;

	// Code of the region hit by a bus read
	typedef logic [3:0]  region_t;

	// Memory address widths
	localparam int PGROM_AW = 15;
	localparam int WKRAM_AW = 14;

	// Region codes
	localparam region_t REG_NONE   = 4'd0;
	localparam region_t REG_PGROM  = 4'd1;
	localparam region_t REG_WKRAM  = 4'd2;
	localparam region_t REG_IN0    = 4'd3;
	localparam region_t REG_JOY    = 4'd4;
	localparam region_t REG_TSTAMP = 4'd5;
	localparam region_t REG_TIMER  = 4'd6;
	localparam region_t REG_MENU   = 4'd7;

	// Memory-mapped input pages, upper address byte
	localparam byte_t PAGE_IN0    = 8'h80;
	localparam byte_t PAGE_JOY    = 8'h81;
	localparam byte_t PAGE_TSTAMP = 8'h88;
	localparam byte_t PAGE_TIMER  = 8'h89;

	// Single-address system triggers
	localparam addr_t ADDR_PAUSE = 16'h8A30;
	localparam addr_t ADDR_MENU  = 16'h8A40;

	// Download index of the program ROM image
	localparam byte_t DN_INDEX_PGROM = 8'd0;

endpackage

//--- flist.f
common/system_pkg.sv
rtl/bus_decode.sv
rtl/ms_timer.sv
rtl/sys_control.sv
memory/program_rom.sv
memory/work_ram.sv
rtl/read_mux.sv
rtl/system_top.sv
bench/tb_system.sv

//--- memory/program_rom.sv
module program_rom (
	input  logic                            clk_24,
	input  logic [system_pkg::PGROM_AW-1:0] rd_addr,
	input  logic                            dn_we,
	input  logic [system_pkg::PGROM_AW-1:0] dn_addr,
	input  system_pkg::byte_t               dn_data,
	output system_pkg::byte_t               q
);
	import system_pkg::*;

	byte_t mem [2**PGROM_AW];

	// Download port, write only
	always_ff @(posedge clk_24)
	begin
		if (dn_we)
			mem[dn_addr] <= dn_data;
	end

	// Bus port, read only
	always_ff @(posedge clk_24)
	begin
		q <= mem[rd_addr];
	end

endmodule

//--- memory/work_ram.sv
module work_ram (
	input  logic                            clk_24,
	input  logic [system_pkg::WKRAM_AW-1:0] addr,
	input  logic                            we,
	input  system_pkg::byte_t               wdata,
	output system_pkg::byte_t               q
);
	import system_pkg::*;

	byte_t mem [2**WKRAM_AW];

	// Read returns the old contents on a write cycle
	always_ff @(posedge clk_24)
	begin
		q <= mem[addr];
		if (we)
			mem[addr] <= wdata;
	end

endmodule

//--- rtl/bus_decode.sv
module bus_decode (
	input  logic                clk_24,
	input  logic                arst_n,
	input  system_pkg::addr_t   bus_addr,
	input  logic                bus_rd,
	input  logic                bus_wr,
	output system_pkg::region_t rd_region,
	output system_pkg::byte_t   rd_offset,
	output logic                rd_valid,
	output logic                wkram_we,
	output logic                timer_clr_we,
	output logic                pause_we,
	output logic                menu_we
);
	import system_pkg::*;

	byte_t   page;
	logic    pgrom_sel;
	logic    wkram_sel;
	logic    timer_sel;
	logic    pause_sel;
	logic    menu_sel;
	region_t region;

	assign page = bus_addr[15:8];

	// Program ROM fills the lower half, work RAM the top quarter
	assign pgrom_sel = ~bus_addr[15];
	assign wkram_sel = bus_addr[15:14] == 2'b11;
	assign timer_sel = page == PAGE_TIMER;
	assign pause_sel = bus_addr == ADDR_PAUSE;
	assign menu_sel  = bus_addr == ADDR_MENU;

	// Writable targets
	assign wkram_we     = bus_wr && wkram_sel;
	assign timer_clr_we = bus_wr && timer_sel;
	assign pause_we     = bus_wr && pause_sel;
	assign menu_we      = bus_wr && menu_sel;

	always_comb
	begin
		if (pgrom_sel)
			region = REG_PGROM;
		else if (wkram_sel)
			region = REG_WKRAM;
		else if (page == PAGE_IN0)
			region = REG_IN0;
		else if (page == PAGE_JOY)
			region = REG_JOY;
		else if (page == PAGE_TSTAMP)
			region = REG_TSTAMP;
		else if (timer_sel)
			region = REG_TIMER;
		else if (menu_sel)
			region = REG_MENU;
		else
			region = REG_NONE;
	end

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_valid  <= 1'b0;
			rd_region <= REG_NONE;
		end
		else
		begin
			rd_valid  <= bus_rd;
			rd_region <= bus_rd ? region : REG_NONE;
		end
	end

	// Low address byte picks the byte inside an input page
	always_ff @(posedge clk_24)
	begin
		if (bus_rd)
			rd_offset <= bus_addr[7:0];
	end

	// Bus master drives at most one strobe per cycle
	a_rd_wr_exclusive: assert property (
		@(posedge clk_24) disable iff (!arst_n) !(bus_rd && bus_wr)
	);

endmodule

//--- rtl/ms_timer.sv
module ms_timer #(
	parameter int CLK_PER_MS = 24000
) (
	input  logic        clk_24,
	input  logic        arst_n,
	input  logic        clr,
	output logic [15:0] count
);
	localparam int PW = (CLK_PER_MS > 1) ? $clog2(CLK_PER_MS) : 1;
	localparam logic [PW-1:0] PRE_LAST = PW'(CLK_PER_MS - 1);

	logic [PW-1:0] prescale;
	logic          ms_tick;

	// Last clock of each millisecond
	assign ms_tick = prescale == PRE_LAST;

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prescale <= '0;
			count    <= '0;
		end
		else if (clr)
		begin
			// Restart a whole millisecond from zero
			prescale <= '0;
			count    <= '0;
		end
		else if (ms_tick)
		begin
			prescale <= '0;
			count    <= count + 16'd1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

//--- rtl/read_mux.sv
module read_mux #(
	parameter int JOY_BYTES = 24
) (
	input  logic                   clk_24,
	input  logic                   arst_n,
	input  system_pkg::region_t    rd_region,
	input  system_pkg::byte_t      rd_offset,
	input  logic                   rd_valid,
	input  system_pkg::byte_t      pgrom_q,
	input  system_pkg::byte_t      wkram_q,
	input  system_pkg::byte_t      status,
	input  logic [JOY_BYTES*8-1:0] joystick,
	input  logic [32:0]            timestamp,
	input  logic [15:0]            timer_count,
	input  logic                   menu_flag,
	output system_pkg::byte_t      bus_rdata,
	output logic                   bus_rvalid
);
	import system_pkg::*;

	// Timestamp is 33 bits, so 5 readable bytes
	localparam int TS_BYTES = 5;

	logic [TS_BYTES*8-1:0] ts_wide;
	byte_t                 joy_byte;
	byte_t                 ts_byte;
	byte_t                 timer_byte;
	byte_t                 sel;

	assign ts_wide = {{(TS_BYTES*8-33){1'b0}}, timestamp};

	// Offsets past the input width read zero
	always_comb
	begin
		joy_byte = '0;
		for (int i = 0; i < JOY_BYTES; i++)
		begin
			if (rd_offset == byte_t'(i))
				joy_byte = joystick[i*8 +: 8];
		end
	end

	always_comb
	begin
		ts_byte = '0;
		for (int i = 0; i < TS_BYTES; i++)
		begin
			if (rd_offset == byte_t'(i))
				ts_byte = ts_wide[i*8 +: 8];
		end
	end

	assign timer_byte = rd_offset[0] ? timer_count[15:8] : timer_count[7:0];

	always_comb
	begin
		case (rd_region)
			REG_PGROM:  sel = pgrom_q;
			REG_WKRAM:  sel = wkram_q;
			REG_IN0:    sel = status;
			REG_JOY:    sel = joy_byte;
			REG_TSTAMP: sel = ts_byte;
			REG_TIMER:  sel = timer_byte;
			REG_MENU:   sel = {8{menu_flag}};
			default:    sel = '0;
		endcase
	end

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			bus_rvalid <= 1'b0;
		else
			bus_rvalid <= rd_valid;
	end

	always_ff @(posedge clk_24)
	begin
		if (rd_valid)
			bus_rdata <= sel;
	end

endmodule

//--- rtl/sys_control.sv
module sys_control (
	input  logic              clk_24,
	input  logic              arst_n,
	input  logic              pause,
	input  logic              menu,
	input  logic              debug,
	input  logic              pause_we,
	input  logic              menu_we,
	output logic              bus_wait,
	output logic              menu_flag,
	output system_pkg::byte_t status
);
	logic pause_trigger;
	logic menu_trigger;

	// Software requests a pause, the external pause input releases it
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			pause_trigger <= 1'b0;
		else if (pause)
			pause_trigger <= 1'b0;
		else if (pause_we)
			pause_trigger <= 1'b1;
	end

	// Menu input latches, software acknowledges by a write
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			menu_trigger <= 1'b0;
		else if (menu)
			menu_trigger <= 1'b1;
		else if (menu_we)
			menu_trigger <= 1'b0;
	end

	assign bus_wait  = pause || pause_trigger;
	assign menu_flag = menu_trigger;

	// Bit 1 is the live menu input, bit 0 the debug strap
	assign status = {6'b000000, menu, debug};

endmodule

//--- rtl/system_top.sv
module system_top #(
	parameter int CLK_PER_MS = 24000,
	parameter int JOY_BYTES  = 24
) (
	input  logic                   clk_24,
	input  logic                   arst_n,

	// Bus formerly driven by the CPU
	input  system_pkg::addr_t      bus_addr,
	input  system_pkg::byte_t      bus_wdata,
	input  logic                   bus_rd,
	input  logic                   bus_wr,
	output system_pkg::byte_t      bus_rdata,
	output logic                   bus_rvalid,
	output logic                   bus_wait,

	// ROM download
	input  system_pkg::dn_addr_t   dn_addr,
	input  system_pkg::byte_t      dn_data,
	input  logic                   dn_wr,
	input  system_pkg::byte_t      dn_index,

	input  logic                   menu,
	input  logic                   pause,
	input  logic [JOY_BYTES*8-1:0] joystick,
	input  logic [32:0]            timestamp,
	input  logic                   debug
);
	import system_pkg::*;

	region_t     rd_region;
	byte_t       rd_offset;
	logic        rd_valid;
	logic        wkram_we;
	logic        timer_clr_we;
	logic        pause_we;
	logic        menu_we;
	logic [15:0] timer_count;
	logic        menu_flag;
	byte_t       status;
	byte_t       pgrom_q;
	byte_t       wkram_q;
	logic        pgrom_dn_we;

	// Only index 0 loads the program ROM
	assign pgrom_dn_we = dn_wr && (dn_index == DN_INDEX_PGROM);

	bus_decode u_decode (
		.clk_24       (clk_24),
		.arst_n       (arst_n),
		.bus_addr     (bus_addr),
		.bus_rd       (bus_rd),
		.bus_wr       (bus_wr),
		.rd_region    (rd_region),
		.rd_offset    (rd_offset),
		.rd_valid     (rd_valid),
		.wkram_we     (wkram_we),
		.timer_clr_we (timer_clr_we),
		.pause_we     (pause_we),
		.menu_we      (menu_we)
	);

	ms_timer #(
		.CLK_PER_MS (CLK_PER_MS)
	) u_timer (
		.clk_24 (clk_24),
		.arst_n (arst_n),
		.clr    (timer_clr_we),
		.count  (timer_count)
	);

	sys_control u_control (
		.clk_24    (clk_24),
		.arst_n    (arst_n),
		.pause     (pause),
		.menu      (menu),
		.debug     (debug),
		.pause_we  (pause_we),
		.menu_we   (menu_we),
		.bus_wait  (bus_wait),
		.menu_flag (menu_flag),
		.status    (status)
	);

	// Program ROM at 0x0000 - 0x7FFF
	program_rom u_pgrom (
		.clk_24  (clk_24),
		.rd_addr (bus_addr[PGROM_AW-1:0]),
		.dn_we   (pgrom_dn_we),
		.dn_addr (dn_addr[PGROM_AW-1:0]),
		.dn_data (dn_data),
		.q       (pgrom_q)
	);

	// Work RAM at 0xC000 - 0xFFFF
	work_ram u_wkram (
		.clk_24 (clk_24),
		.addr   (bus_addr[WKRAM_AW-1:0]),
		.we     (wkram_we),
		.wdata  (bus_wdata),
		.q      (wkram_q)
	);

	read_mux #(
		.JOY_BYTES (JOY_BYTES)
	) u_mux (
		.clk_24      (clk_24),
		.arst_n      (arst_n),
		.rd_region   (rd_region),
		.rd_offset   (rd_offset),
		.rd_valid    (rd_valid),
		.pgrom_q     (pgrom_q),
		.wkram_q     (wkram_q),
		.status      (status),
		.joystick    (joystick),
		.timestamp   (timestamp),
		.timer_count (timer_count),
		.menu_flag   (menu_flag),
		.bus_rdata   (bus_rdata),
		.bus_rvalid  (bus_rvalid)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the system bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_system \
	-f flist.f --Mdir obj_dir -o tb_system_sim > build.log 2>&1 \
	&& ./obj_dir/tb_system_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
